/* env_pkg.sv */
`default_nettype none

package env_pkg;

    localparam int num_slots       = 18;  // one bank of operators
    localparam int slot_width      = 5;
    localparam int env_width       = 9;   // attenuation, 0.1875 dB units
    localparam int rate_width      = 4;   // ar, dr, sl, rr
    localparam int tl_width        = 6;
    localparam int ksl_width       = 2;
    localparam int fnum_width      = 10;
    localparam int block_width     = 3;
    localparam int frame_cnt_width = 15;
    localparam int step_width      = 4;   // steps of 0, 1, 2, 4, 8
    localparam int pipe_delay      = 3;   // strobe to env_valid

    localparam logic [env_width-1:0] silence = 9'd511;  // fully attenuated

    localparam int eff_rate_width = 6;    // effective rate 0..63
    localparam logic [eff_rate_width-1:0] max_eff_rate = 6'd63;
    localparam int fast_q         = 12;   // rate quotient where per-frame steps begin
    localparam int sl_shift       = 4;    // sustain level compares against env / 16
    localparam int atk_shift      = 3;    // attack decrement is env * step / 8

    localparam int ksl_add_width  = 8;
    localparam int fnum_hi_width  = 4;    // top fnum bits index the ksl table
    localparam int ksl_oct_step   = 8;    // ksl base drop per octave
    localparam int ksl_top_block  = 7;    // octave with the full ksl base

    // ADSR phase kept per slot
    typedef enum logic [1:0] {
        ph_attack  = 2'd0,
        ph_decay   = 2'd1,
        ph_sustain = 2'd2,
        ph_release = 2'd3
    } env_phase_t;

    // operator register set, delivered with each strobe
    typedef struct packed {
        logic [rate_width-1:0]  ar;     // attack rate
        logic [rate_width-1:0]  dr;     // decay rate
        logic [rate_width-1:0]  sl;     // sustain level
        logic [rate_width-1:0]  rr;     // release rate
        logic [tl_width-1:0]    tl;     // total level
        logic                   ksr;    // key scale rate
        logic [ksl_width-1:0]   ksl;    // key scale level select
        logic                   egt;    // sustained envelope type
        logic [fnum_width-1:0]  fnum;
        logic [block_width-1:0] block;  // octave
    } op_settings_t;

    typedef struct packed {
        logic [env_width-1:0] env;
        env_phase_t           phase;
    } env_out_t;

    // one stage of the top-level strobe pipeline
    typedef struct packed {
        logic         valid;
        env_phase_t   phase;
        op_settings_t settings;
    } pipe_stage_t;

    localparam pipe_stage_t pipe_idle = '{
        valid:    1'b0,
        phase:    ph_release,
        settings: '0
    };

    // cycle-1 stage inside the level update
    typedef struct packed {
        logic                  valid;
        logic [slot_width-1:0] slot;
        env_phase_t            phase;
        logic [env_width-1:0]  env;
    } level_stage_t;

    localparam level_stage_t level_idle = '{
        valid: 1'b0,
        slot:  '0,
        phase: ph_release,
        env:   silence
    };

    localparam env_out_t out_idle = '{
        env:   silence,
        phase: ph_release
    };

endpackage

`default_nettype wire

/* env_state_fsm.sv */
`default_nettype none

module env_state_fsm (
    input  logic                             clk,
    input  logic                             arst_n,
    input  logic                             sample_clk_en,  // one slot per strobe
    input  logic [env_pkg::slot_width-1:0]   slot,
    input  env_pkg::op_settings_t            settings,
    input  logic                             key_on,
    input  logic                             key_off,
    input  logic [env_pkg::env_width-1:0]    env_at_rd,      // stored attenuation, cycle 0
    output env_pkg::env_phase_t              phase_next,
    output logic [env_pkg::rate_width-1:0]   rate_req
);

    env_pkg::env_phase_t phase_mem [env_pkg::num_slots];  // per-slot ADSR phase
    env_pkg::env_phase_t phase_cur;
    logic [env_pkg::env_width-env_pkg::sl_shift-1:0] env_coarse;  // env / 16
    logic [env_pkg::env_width-env_pkg::sl_shift-1:0] sl_ext;

    assign phase_cur  = phase_mem[slot];  // async read in cycle 0
    assign env_coarse = env_at_rd[env_pkg::env_width-1:env_pkg::sl_shift];
    assign sl_ext     = (env_pkg::env_width-env_pkg::sl_shift)'(settings.sl);

    always_comb begin
        phase_next = phase_cur;
        case (phase_cur)
            env_pkg::ph_attack: begin
                if (env_at_rd == '0)
                    phase_next = env_pkg::ph_decay;  // peak reached
            end
            env_pkg::ph_decay: begin
                if (env_coarse >= sl_ext)
                    phase_next = env_pkg::ph_sustain;  // down to sustain level
            end
            env_pkg::ph_sustain: begin
                if (!settings.egt)
                    phase_next = env_pkg::ph_release;  // percussive tone moves on
            end
            default: ;  // release holds until a key event
        endcase
        if (key_on)
            phase_next = env_pkg::ph_attack;  // key_on wins
        else if (key_off)
            phase_next = env_pkg::ph_release;
    end

    always_comb begin
        case (phase_next)
            env_pkg::ph_attack:  rate_req = settings.ar;
            env_pkg::ph_decay:   rate_req = settings.dr;
            env_pkg::ph_sustain: rate_req = '0;  // level frozen
            default:             rate_req = settings.rr;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < env_pkg::num_slots; i++) begin
                phase_mem[i] <= env_pkg::ph_release;  // all slots silent
            end
        end else if (sample_clk_en) begin
            phase_mem[slot] <= phase_next;  // write back at end of cycle 0
        end
    end

endmodule

`default_nettype wire

/* env_rate_counter.sv */
`default_nettype none

module env_rate_counter (
    input  logic                              clk,
    input  logic                              arst_n,
    input  logic                              sample_clk_en,
    input  logic                              frame_end,   // last slot of the frame
    input  logic [env_pkg::rate_width-1:0]    rate_req,
    input  logic                              ksr,
    input  logic [env_pkg::block_width-1:0]   block,
    output logic [env_pkg::step_width-1:0]    step         // valid in cycle 1
);

    localparam int q_width = env_pkg::eff_rate_width - 2;  // effective rate / 4

    logic [env_pkg::frame_cnt_width-1:0] frame_cnt;   // shared by all slots
    logic [env_pkg::block_width-1:0]     key_ofs;
    logic [env_pkg::eff_rate_width:0]    eff_sum;     // one spare bit before the cap
    logic [env_pkg::eff_rate_width-1:0]  eff_rate;
    logic [q_width-1:0]                  q;
    logic [env_pkg::frame_cnt_width-1:0] frame_mask;
    logic [env_pkg::step_width-1:0]      step_calc;

    // key scaling, full block with ksr, coarse otherwise
    assign key_ofs = ksr ? block : (block >> 2);

    assign eff_sum = (env_pkg::eff_rate_width+1)'({rate_req, 2'b00})
                   + (env_pkg::eff_rate_width+1)'(key_ofs);

    assign eff_rate = (eff_sum > env_pkg::max_eff_rate) ? env_pkg::max_eff_rate
                                                        : eff_sum[env_pkg::eff_rate_width-1:0];

    assign q = eff_rate[env_pkg::eff_rate_width-1:2];

    always_comb begin
        frame_mask = '0;
        if (rate_req == '0) begin
            step_calc = '0;  // rate 0 never moves
        end else if (q >= env_pkg::fast_q) begin
            // several units per frame at the top rates
            step_calc = env_pkg::step_width'(1) << (q - env_pkg::fast_q);
        end else begin
            // one unit every 2^(12-q) frames
            frame_mask = (env_pkg::frame_cnt_width'(1) << (env_pkg::fast_q - q))
                       - env_pkg::frame_cnt_width'(1);
            step_calc  = ((frame_cnt & frame_mask) == '0) ? env_pkg::step_width'(1) : '0;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            frame_cnt <= '0;
            step      <= '0;
        end else begin
            step <= step_calc;  // registered step for cycle 1
            if (sample_clk_en && frame_end)
                frame_cnt <= frame_cnt + 1'b1;  // wraps freely
        end
    end

endmodule

`default_nettype wire

/* env_level_update.sv */
`default_nettype none

module env_level_update (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            sample_clk_en,
    input  logic [env_pkg::slot_width-1:0]  slot,
    input  env_pkg::env_phase_t             phase_next,
    input  logic [env_pkg::step_width-1:0]  step,        // from rate counter, cycle 1
    output logic [env_pkg::env_width-1:0]   env_at_rd,   // cycle 0
    output logic [env_pkg::env_width-1:0]   env_new      // cycle 2
);

    localparam int prod_width = env_pkg::env_width + env_pkg::step_width;

    logic [env_pkg::env_width-1:0] env_mem [env_pkg::num_slots];  // per-slot attenuation
    env_pkg::level_stage_t         lvl_p1;
    logic [prod_width-1:0]         atk_prod;
    logic [env_pkg::env_width:0]   atk_dec;    // up to 512
    logic [env_pkg::env_width:0]   rise_sum;   // carry shows overflow
    logic [env_pkg::env_width-1:0] env_calc;

    assign env_at_rd = env_mem[slot];  // async read

    assign atk_prod = prod_width'(lvl_p1.env) * prod_width'(step);
    assign atk_dec  = atk_prod[prod_width-1:env_pkg::atk_shift] + 1'b1;  // env*step/8 + 1
    assign rise_sum = {1'b0, lvl_p1.env} + (env_pkg::env_width+1)'(step);

    always_comb begin
        env_calc = lvl_p1.env;  // sustain and idle steps hold
        case (lvl_p1.phase)
            env_pkg::ph_attack: begin
                if (step != '0 && lvl_p1.env != '0) begin
                    if (atk_dec >= {1'b0, lvl_p1.env})
                        env_calc = '0;  // never below full volume
                    else
                        env_calc = lvl_p1.env - atk_dec[env_pkg::env_width-1:0];
                end
            end
            env_pkg::ph_decay, env_pkg::ph_release: begin
                if (rise_sum > {1'b0, env_pkg::silence})
                    env_calc = env_pkg::silence;  // saturate
                else
                    env_calc = rise_sum[env_pkg::env_width-1:0];
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            lvl_p1 <= env_pkg::level_idle;
            for (int i = 0; i < env_pkg::num_slots; i++) begin
                env_mem[i] <= env_pkg::silence;
            end
        end else begin
            lvl_p1 <= '{valid: sample_clk_en, slot: slot, phase: phase_next, env: env_at_rd};
            if (lvl_p1.valid)
                env_mem[lvl_p1.slot] <= env_calc;  // write back end of cycle 1
        end
    end

    always_ff @(posedge clk) begin
        env_new <= env_calc;
    end

endmodule

`default_nettype wire

/* ksl_rom.sv */
`default_nettype none

module ksl_rom (
    input  logic                                clk,
    input  logic [env_pkg::fnum_hi_width-1:0]   fnum_hi,
    input  logic [env_pkg::block_width-1:0]     block,
    input  logic [env_pkg::ksl_width-1:0]       ksl,
    output logic [env_pkg::ksl_add_width-1:0]   ksl_add    // valid in cycle 2
);

    logic [env_pkg::ksl_add_width-1:0] ksl_base;   // top-octave value
    logic [env_pkg::ksl_add_width-1:0] oct_drop;   // 8 per octave below 7
    logic [env_pkg::ksl_add_width-1:0] ksl_oct;
    logic [env_pkg::ksl_add_width-1:0] ksl_calc;

    always_comb begin
        case (fnum_hi)
            4'd0:    ksl_base = 8'd0;
            4'd1:    ksl_base = 8'd24;
            4'd2:    ksl_base = 8'd32;
            4'd3:    ksl_base = 8'd37;
            4'd4:    ksl_base = 8'd40;
            4'd5:    ksl_base = 8'd43;
            4'd6:    ksl_base = 8'd45;
            4'd7:    ksl_base = 8'd47;
            4'd8:    ksl_base = 8'd48;
            4'd9:    ksl_base = 8'd50;
            4'd10:   ksl_base = 8'd51;
            4'd11:   ksl_base = 8'd52;
            4'd12:   ksl_base = 8'd53;
            4'd13:   ksl_base = 8'd54;
            4'd14:   ksl_base = 8'd55;
            default: ksl_base = 8'd56;
        endcase
    end

    assign oct_drop = env_pkg::ksl_add_width'(env_pkg::ksl_oct_step)
                    * env_pkg::ksl_add_width'(env_pkg::ksl_top_block - int'(block));

    assign ksl_oct = (ksl_base > oct_drop) ? (ksl_base - oct_drop) : '0;  // floor at 0

    always_comb begin
        case (ksl)
            2'd0:    ksl_calc = '0;              // scaling off
            2'd1:    ksl_calc = ksl_oct >> 1;
            2'd2:    ksl_calc = ksl_oct >> 2;
            default: ksl_calc = ksl_oct;         // full slope
        endcase
    end

    always_ff @(posedge clk) begin
        ksl_add <= ksl_calc;
    end

endmodule

`default_nettype wire

/* env_output_stage.sv */
`default_nettype none

module env_output_stage (
    input  logic                               clk,
    input  logic                               arst_n,
    input  logic                               valid_in,   // strobe, cycle 2
    input  logic [env_pkg::env_width-1:0]      env_new,
    input  logic [env_pkg::tl_width-1:0]       tl,
    input  logic [env_pkg::ksl_add_width-1:0]  ksl_add,
    input  env_pkg::env_phase_t                phase,
    output logic                               env_valid,  // cycle 3
    output env_pkg::env_out_t                  result
);

    logic [env_pkg::env_width:0]   level_sum;  // max 1018, fits 10 bits
    logic [env_pkg::env_width-1:0] level_clamped;

    assign level_sum = (env_pkg::env_width+1)'(env_new)
                     + (env_pkg::env_width+1)'({tl, 2'b00})  // tl in 0.75 dB units
                     + (env_pkg::env_width+1)'(ksl_add);

    assign level_clamped = (level_sum > {1'b0, env_pkg::silence}) ? env_pkg::silence
                                                                 : level_sum[env_pkg::env_width-1:0];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            env_valid <= 1'b0;
            result    <= env_pkg::out_idle;
        end else begin
            env_valid <= valid_in;  // one result per strobe
            if (valid_in)
                result <= '{env: level_clamped, phase: phase};  // holds between strobes
        end
    end

endmodule

`default_nettype wire

/* envelope_generator.sv */
`default_nettype none

module envelope_generator (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic                            sample_clk_en,
    input  logic [env_pkg::slot_width-1:0]  slot,
    input  env_pkg::op_settings_t           settings,
    input  logic                            key_on,
    input  logic                            key_off,
    input  logic                            frame_end,
    output logic                            env_valid,
    output env_pkg::env_out_t               result
);

    // stages 1 and 2, the output stage holds stage 3
    env_pkg::pipe_stage_t pipe [1:env_pkg::pipe_delay-1];

    env_pkg::env_phase_t                phase_next;
    logic [env_pkg::rate_width-1:0]     rate_req;
    logic [env_pkg::step_width-1:0]     step;
    logic [env_pkg::env_width-1:0]      env_at_rd;
    logic [env_pkg::env_width-1:0]      env_new;
    logic [env_pkg::ksl_add_width-1:0]  ksl_add;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 1; i < env_pkg::pipe_delay; i++) begin
                pipe[i] <= env_pkg::pipe_idle;
            end
        end else begin
            pipe[1] <= '{valid: sample_clk_en, phase: phase_next, settings: settings};
            for (int i = 2; i < env_pkg::pipe_delay; i++) begin
                pipe[i] <= pipe[i-1];  // shift down
            end
        end
    end

    env_state_fsm u_state_fsm (
        .clk           (clk),
        .arst_n        (arst_n),
        .sample_clk_en (sample_clk_en),
        .slot          (slot),
        .settings      (settings),
        .key_on        (key_on),
        .key_off       (key_off),
        .env_at_rd     (env_at_rd),
        .phase_next    (phase_next),
        .rate_req      (rate_req)
    );

    env_rate_counter u_rate_counter (
        .clk           (clk),
        .arst_n        (arst_n),
        .sample_clk_en (sample_clk_en),
        .frame_end     (frame_end),
        .rate_req      (rate_req),
        .ksr           (settings.ksr),
        .block         (settings.block),
        .step          (step)
    );

    env_level_update u_level_update (
        .clk           (clk),
        .arst_n        (arst_n),
        .sample_clk_en (sample_clk_en),
        .slot          (slot),
        .phase_next    (phase_next),
        .step          (step),
        .env_at_rd     (env_at_rd),
        .env_new       (env_new)
    );

    ksl_rom u_ksl_rom (
        .clk     (clk),
        .fnum_hi (pipe[1].settings.fnum[env_pkg::fnum_width-1 -: env_pkg::fnum_hi_width]),
        .block   (pipe[1].settings.block),
        .ksl     (pipe[1].settings.ksl),
        .ksl_add (ksl_add)
    );

    env_output_stage u_output_stage (
        .clk       (clk),
        .arst_n    (arst_n),
        .valid_in  (pipe[env_pkg::pipe_delay-1].valid),
        .env_new   (env_new),
        .tl        (pipe[env_pkg::pipe_delay-1].settings.tl),
        .ksl_add   (ksl_add),
        .phase     (pipe[env_pkg::pipe_delay-1].phase),
        .env_valid (env_valid),
        .result    (result)
    );

endmodule

`default_nettype wire

/* tb_envelope_generator.sv */
`default_nettype none

module tb_envelope_generator;

    timeunit 1ns;
    timeprecision 1ps;

    logic                           clk;
    logic                           arst_n;
    logic                           sample_clk_en;
    logic [env_pkg::slot_width-1:0] slot;
    env_pkg::op_settings_t          settings;
    logic                           key_on;
    logic                           key_off;
    logic                           frame_end;
    logic                           env_valid;
    env_pkg::env_out_t              result;

    string                 tc_name [$];    // one entry per case line
    int                    tc_slot [$];
    int                    tc_key [$];     // 0 none, 1 on, 2 off
    int                    tc_frames [$];
    env_pkg::op_settings_t tc_cfg [$];
    env_pkg::env_out_t     tc_exp [$];

    env_pkg::env_out_t     exp_q [$];      // one per strobe, in strobe order
    bit                    chk_q [$];
    int                    tst_q [$];
    env_pkg::op_settings_t slot_cfg [env_pkg::num_slots];  // kept once a slot is targeted
    bit                    slot_used [env_pkg::num_slots];
    int                    n_sent;
    int                    n_seen;
    real                   wd_limit;
    env_pkg::env_out_t     mon_exp;
    bit                    mon_chk;
    int                    mon_tst;

    envelope_generator u_dut (
        .clk           (clk),
        .arst_n        (arst_n),
        .sample_clk_en (sample_clk_en),
        .slot          (slot),
        .settings      (settings),
        .key_on        (key_on),
        .key_off       (key_off),
        .frame_end     (frame_end),
        .env_valid     (env_valid),
        .result        (result)
    );

    initial clk = 1'b0;
    always #2 clk = ~clk;  // 4 ns period

    task automatic check_env(input string name, input logic [env_pkg::env_width-1:0] exp_v,
                             input logic [env_pkg::env_width-1:0] act_v);
        if (act_v !== exp_v) begin
            $display("mismatch %s env expected %0d actual %0d", name, exp_v, act_v);
            $display("Test FAILED");
            $fatal(1, "attenuation compare failed");
        end
    endtask

    task automatic check_phase(input string name, input env_pkg::env_phase_t exp_v,
                               input env_pkg::env_phase_t act_v);
        if (act_v !== exp_v) begin
            $display("mismatch %s phase expected %s actual %s", name, exp_v.name(), act_v.name());
            $display("Test FAILED");
            $fatal(1, "phase compare failed");
        end
    endtask

    // results come back in strobe order, one per env_valid pulse
    always @(posedge clk) begin
        if (env_valid) begin
            if (exp_q.size() == 0) begin
                $display("env_valid pulsed with no strobe outstanding");
                $display("Test FAILED");
                $fatal(1, "unexpected result");
            end else begin
                mon_exp = exp_q.pop_front();
                mon_chk = chk_q.pop_front();
                mon_tst = tst_q.pop_front();
                if (mon_chk) begin
                    check_env(tc_name[mon_tst], mon_exp.env, result.env);
                    check_phase(tc_name[mon_tst], mon_exp.phase, result.phase);
                end
                n_seen++;
            end
        end
    end

    task automatic send_strobe(input int s, input env_pkg::op_settings_t cfg, input int key,
                               input bit chk, input env_pkg::env_out_t exp_v, input int tst);
        @(posedge clk);
        sample_clk_en <= 1'b1;
        slot          <= s[env_pkg::slot_width-1:0];
        settings      <= cfg;
        key_on        <= (key == 1);
        key_off       <= (key == 2);
        frame_end     <= (s == env_pkg::num_slots - 1);  // last slot closes the frame
        exp_q.push_back(exp_v);
        chk_q.push_back(chk);
        tst_q.push_back(tst);
        n_sent++;
    endtask

    task automatic run_test(input int t);
        env_pkg::op_settings_t cfg;
        env_pkg::env_out_t     exp_v;
        logic [63:0]           rnd;
        bit                    chk;
        int                    key;
        slot_cfg[tc_slot[t]]  = tc_cfg[t];
        slot_used[tc_slot[t]] = 1'b1;
        for (int f = 0; f < tc_frames[t]; f++) begin
            for (int s = 0; s < env_pkg::num_slots; s++) begin
                key = 0;
                if (slot_used[s]) begin
                    cfg = slot_cfg[s];
                    chk = 1'b0;  // earlier targets drift on, not checked
                end else begin
                    rnd   = {$urandom, $urandom};
                    cfg   = rnd[$bits(env_pkg::op_settings_t)-1:0];
                    chk   = 1'b1;  // never keyed, stays silent in release
                    exp_v = '{env: env_pkg::silence, phase: env_pkg::ph_release};
                end
                if (s == tc_slot[t]) begin
                    key   = (f == 0) ? tc_key[t] : 0;  // key event in the first frame only
                    chk   = (f == tc_frames[t] - 1);
                    exp_v = tc_exp[t];
                end
                send_strobe(s, cfg, key, chk, exp_v, t);
            end
        end
    endtask

    initial begin
        int                    fd;
        int                    n;
        int                    total_frames;
        int                    v [15];
        string                 line;
        string                 name;
        env_pkg::op_settings_t cfg;
        env_pkg::env_out_t     e;
        void'($urandom(60));
        arst_n        = 1'b0;
        sample_clk_en = 1'b0;
        slot          = '0;
        settings      = '0;
        key_on        = 1'b0;
        key_off       = 1'b0;
        frame_end     = 1'b0;
        n_sent        = 0;
        n_seen        = 0;
        wd_limit      = 0.0;
        total_frames  = 0;
        fd = $fopen("env_cases.txt", "r");
        if (fd == 0) begin
            $display("could not open the case file env_cases.txt");
            $display("Test FAILED");
            $fatal(1, "no cases");
        end
        while (!$feof(fd)) begin
            line = "";
            n    = $fgets(line, fd);
            if (line.len() < 2 || line[0] == "#")
                continue;  // blank or column note
            n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d %d %d", name,
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7], v[8], v[9], v[10],
                        v[11], v[12], v[13], v[14]);
            if (n != 16) begin
                $display("case line has %0d fields instead of 16: %s", n, line);
                $display("Test FAILED");
                $fatal(1, "bad case file");
            end
            cfg.ar    = env_pkg::rate_width'(v[1]);
            cfg.dr    = env_pkg::rate_width'(v[2]);
            cfg.sl    = env_pkg::rate_width'(v[3]);
            cfg.rr    = env_pkg::rate_width'(v[4]);
            cfg.tl    = env_pkg::tl_width'(v[5]);
            cfg.ksr   = v[6][0];
            cfg.ksl   = env_pkg::ksl_width'(v[7]);
            cfg.egt   = v[8][0];
            cfg.fnum  = env_pkg::fnum_width'(v[9]);
            cfg.block = env_pkg::block_width'(v[10]);
            e.env     = env_pkg::env_width'(v[13]);
            e.phase   = env_pkg::env_phase_t'(v[14][1:0]);
            tc_name.push_back(name);
            tc_slot.push_back(v[0]);
            tc_cfg.push_back(cfg);
            tc_key.push_back(v[11]);
            tc_frames.push_back(v[12]);
            tc_exp.push_back(e);
            total_frames += v[12];
        end
        $fclose(fd);
        wd_limit = real'(total_frames) * 18.0 * 4.0 * 2.0 + 100.0;  // frames, slots, period, margin
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        for (int t = 0; t < tc_name.size(); t++) begin
            run_test(t);
        end
        @(posedge clk);
        sample_clk_en <= 1'b0;
        key_on        <= 1'b0;
        key_off       <= 1'b0;
        frame_end     <= 1'b0;
        while (n_seen < n_sent) @(posedge clk);  // drain the pipeline
        repeat (env_pkg::pipe_delay + 1) @(posedge clk);  // an extra env_valid reaches the monitor
        $display("Test OK");
        $finish;
    end

    initial begin
        wait (wd_limit > 0.0);
        #(wd_limit);
        $display("watchdog expired before all results came back");
        $display("Test FAILED");
        $fatal(1, "timeout");
    end

endmodule

`default_nettype wire

/* env_cases.txt */
# name slot ar dr sl rr tl ksr ksl egt fnum block key(0 none 1 on 2 off) frames
# exp_env exp_phase(0 attack 1 decay 2 sustain 3 release), checked on the last frame
reset_idle        0 0  0 0  0  0 0 0 0 0    0 0 1   511 3
attack_peak       1 15 4 2  0  0 0 0 1 0    0 1 1   0   0
attack_to_decay   1 15 4 2  0  0 0 0 1 0    0 0 1   0   1
decay_slow_hold   1 15 4 2  0  0 0 0 1 0    0 0 253 0   1
decay_slow_step   1 15 4 2  0  0 0 0 1 0    0 0 1   1   1
decay_to_sustain  1 15 12 2 0  0 0 0 1 0    0 0 34  32  2
sustain_release   1 15 12 2 13 0 0 0 0 0    0 0 1   34  3
release_saturate  1 15 12 2 15 0 0 0 0 0    0 2 70  511 3
tl_ksl_add        3 15 0 0  15 20 0 3 1 1023 7 1 1   136 0
tl_ksl_clamp      3 15 0 0  15 20 0 3 1 1023 7 2 50  511 3
pair_a_on         4 15 12 15 0 0 0 0 1 0    0 1 1   0   0
pair_b_on         5 15 0 15 12 0 0 0 1 0    0 1 1   0   0
pair_a_decay      4 15 12 15 0 0 0 0 1 0    0 0 3   4   1
pair_b_off        5 15 0 15 12 0 0 0 1 0    0 2 1   1   3
ksl_half          6 15 0 0  0  0 1 1 1 512  5 1 1   16  0

/* sim.f */
env_pkg.sv
env_state_fsm.sv
env_rate_counter.sv
env_level_update.sv
ksl_rom.sv
env_output_stage.sv
envelope_generator.sv
tb_envelope_generator.sv

/* Bender.yml */
package:
  name: envelope_generator

sources:
  - files:
      - env_pkg.sv
      - env_state_fsm.sv
      - env_rate_counter.sv
      - env_level_update.sv
      - ksl_rom.sv
      - env_output_stage.sv
      - envelope_generator.sv
  - target: test
    files:
      - tb_envelope_generator.sv
